// File: compile.f
+incdir+.
lc3b_types.sv
stage_link.sv
lc3b_regfile.sv
lc3b_fetch.sv
lc3b_decode.sv
lc3b_execute.sv
lc3b_memory.sv
lc3b_writeback.sv
cpu_datapath.sv
cpu_chk.sv
tb_cpu.sv

// File: cpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_chk import lc3b_types::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     instruction_request,
  input logic     instruction_response,
  input lc3b_word instruction_address,
  input logic     data_request,
  input logic     data_response,
  input logic     data_write,
  input lc3b_word data_address,
  input lc3b_word write_data
);

  int error_count = 0;  // Polled by the testbench.

  // A fetch holds its request and address until memory answers.
  a_instr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instruction_request && !instruction_response |=>
      instruction_request && $stable(instruction_address))
    else begin
      $error("instruction request or address changed before the response");
      error_count++;
    end

  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    data_request && !data_response |=>
      data_request && $stable(data_address) && $stable(data_write) && $stable(write_data))
    else begin
      $error("data request, address or write data changed before the response");
      error_count++;
    end

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !instruction_request && !data_request && !data_write)
    else begin
      $error("memory request high while reset is asserted");
      error_count++;
    end

  a_write_qualified: assert property (@(posedge clk) disable iff (!rst_n)
    data_write |-> data_request)  // A write is part of a request.
    else begin
      $error("data_write high without data_request");
      error_count++;
    end

endmodule : cpu_chk

`default_nettype wire

// File: cpu_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath import lc3b_types::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  lc3b_word instr,
  input  logic     instruction_response,
  input  lc3b_word read_data,
  input  logic     data_response,
  output logic     instruction_request,
  output lc3b_word instruction_address,
  output logic     data_request,
  output logic     data_write,
  output lc3b_word data_address,
  output lc3b_word write_data
);

  logic     advance, fetch_advance;
  logic     fetch_ready, decode_ready, memory_ready, writeback_ready;
  logic     if_id_hold, ex_dest_busy, branch_done;
  logic     redirect, branch_resolved, fetch_resume;
  lc3b_word redirect_pc;
  lc3b_reg  wb_dest;
  lc3b_word wb_data;
  logic     wb_load;

  stage_link #(.payload_t(id_payload_t))  if_id ();
  stage_link #(.payload_t(ex_payload_t))  id_ex ();
  stage_link #(.payload_t(mem_payload_t)) ex_mem ();
  stage_link #(.payload_t(wb_payload_t))  mem_wb ();

  assign decode_ready  = 1'b1;  // Interlock inserts bubbles instead of stalling.
  assign advance       = fetch_ready & decode_ready & memory_ready & writeback_ready;
  assign fetch_advance = advance & !if_id_hold;  // IF/ID holds while decode waits.
  assign ex_dest_busy  = id_ex.valid & id_ex.ctrl.load_regfile;
  assign fetch_resume  = redirect | (branch_resolved & branch_done);

  lc3b_fetch u_fetch (
    .clk, .rst_n,
    .advance     (fetch_advance),
    .redirect    (fetch_resume),
    .redirect_pc,
    .instr,
    .instruction_response,
    .instruction_request,
    .instruction_address,
    .fetch_ready,
    .if_id       (if_id.src)
  );

  lc3b_decode u_decode (
    .clk, .rst_n, .advance,
    .if_id       (if_id.dst),
    .id_ex       (id_ex.src),
    .ex_dest_busy,
    .wb_dest, .wb_data, .wb_load,
    .ex_mem_view (ex_mem.dst),
    .mem_wb_view (mem_wb.dst),
    .branch_done,
    .if_id_hold
  );

  lc3b_execute u_execute (
    .clk, .rst_n, .advance,
    .id_ex  (id_ex.dst),
    .ex_mem (ex_mem.src)
  );

  lc3b_memory u_memory (
    .clk, .rst_n, .advance,
    .ex_mem (ex_mem.dst),
    .mem_wb (mem_wb.src),
    .data_request, .data_write, .data_address, .write_data,
    .read_data, .data_response,
    .memory_ready
  );

  lc3b_writeback u_writeback (
    .clk, .rst_n, .advance,
    .mem_wb (mem_wb.dst),
    .wb_dest, .wb_data, .wb_load,
    .redirect, .redirect_pc,
    .branch_resolved,
    .writeback_ready
  );

endmodule : cpu_datapath

`default_nettype wire

// File: lc3b_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_macros.svh"

module lc3b_decode import lc3b_types::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     advance,
  stage_link.dst   if_id,
  stage_link.src   id_ex,
  input  logic     ex_dest_busy,
  input  lc3b_reg  wb_dest,
  input  lc3b_word wb_data,
  input  logic     wb_load,
  stage_link.dst   ex_mem_view,
  stage_link.dst   mem_wb_view,
  output logic     branch_done,
  output logic     if_id_hold
);

  lc3b_word         instr;
  lc3b_opcode       opcode;
  lc3b_control_word ctrl;
  lc3b_word         sr1, sr2;
  logic             uses_src1, uses_src2;
  logic             stall;
  logic             busy [`LC3B_INTERLOCK_DEPTH];
  lc3b_reg          busy_dest [`LC3B_INTERLOCK_DEPTH];

  assign instr  = if_id.payload.instruction;
  assign opcode = lc3b_opcode'(instr[15:12]);

  // Control ROM.
  always_comb begin
    ctrl      = '0;
    ctrl.dest = instr[11:9];
    ctrl.src1 = instr[8:6];
    ctrl.src2 = instr[2:0];
    uses_src1 = 1'b0;
    uses_src2 = 1'b0;
    case (opcode)
      op_add, op_and: begin
        ctrl.aluop        = (opcode == op_add) ? alu_add : alu_and;
        ctrl.alumux_sel   = instr[5];
        ctrl.load_regfile = 1'b1;
        ctrl.load_cc      = 1'b1;
        uses_src1         = 1'b1;
        uses_src2         = !instr[5];
      end
      op_not: begin
        ctrl.aluop        = alu_not;
        ctrl.load_regfile = 1'b1;
        ctrl.load_cc      = 1'b1;
        uses_src1         = 1'b1;
      end
      op_ldr: begin
        ctrl.aluop        = alu_pass;
        ctrl.mem_read     = 1'b1;
        ctrl.load_regfile = 1'b1;
        ctrl.load_cc      = 1'b1;
        uses_src1         = 1'b1;
      end
      op_str: begin
        ctrl.mem_write = 1'b1;
        ctrl.src2      = instr[11:9];  // Store data comes from SR.
        uses_src1      = 1'b1;
        uses_src2      = 1'b1;
      end
      op_br: begin
        ctrl.is_branch  = 1'b1;
        ctrl.branch_nzp = instr[11:9];
      end
      default: ;  // Unsupported opcodes run as no-ops.
    endcase
  end

  lc3b_regfile u_regfile (
    .clk,
    .rst_n,
    .load  (wb_load),
    .dest  (wb_dest),
    .in    (wb_data),
    .src_a (ctrl.src1),
    .src_b (ctrl.src2),
    .reg_a (sr1),
    .reg_b (sr2)
  );

  // Pending destinations, youngest first.
  assign busy[0]      = ex_dest_busy;
  assign busy_dest[0] = id_ex.ctrl.dest;
  assign busy[1]      = ex_mem_view.valid & ex_mem_view.ctrl.load_regfile;
  assign busy_dest[1] = ex_mem_view.ctrl.dest;
  assign busy[2]      = mem_wb_view.valid & mem_wb_view.ctrl.load_regfile;
  assign busy_dest[2] = mem_wb_view.ctrl.dest;

  always_comb begin
    stall = 1'b0;
    for (int i = 0; i < `LC3B_INTERLOCK_DEPTH; i++) begin
      if (busy[i] && ((uses_src1 && busy_dest[i] == ctrl.src1) ||
                      (uses_src2 && busy_dest[i] == ctrl.src2)))
        stall = 1'b1;
    end
  end

  assign if_id_hold  = if_id.valid & stall;
  assign branch_done = mem_wb_view.valid & mem_wb_view.ctrl.is_branch;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else if (advance) begin
      id_ex.valid <= if_id.valid & !stall;  // Bubble on a hazard.
      id_ex.pc    <= if_id.pc;
      id_ex.ctrl  <= ctrl;
      id_ex.payload.sr1    <= sr1;
      id_ex.payload.sr2    <= sr2;
      id_ex.payload.offset <= ctrl.is_branch ? {{7{instr[8]}}, instr[8:0]}
                                             : {{10{instr[5]}}, instr[5:0]};
      id_ex.payload.imm5   <= {{11{instr[4]}}, instr[4:0]};
    end
  end

endmodule : lc3b_decode

`default_nettype wire

// File: lc3b_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_execute import lc3b_types::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   advance,
  stage_link.dst id_ex,
  stage_link.src ex_mem
);

  lc3b_word alu_b;
  lc3b_word alu_out;
  lc3b_word mem_addr;
  lc3b_word br_target;

  assign alu_b = id_ex.ctrl.alumux_sel ? id_ex.payload.imm5 : id_ex.payload.sr2;

  always_comb begin
    case (id_ex.ctrl.aluop)
      alu_add: alu_out = id_ex.payload.sr1 + alu_b;
      alu_and: alu_out = id_ex.payload.sr1 & alu_b;
      alu_not: alu_out = ~id_ex.payload.sr1;
      default: alu_out = alu_b;
    endcase
  end

  // Word offsets are scaled by two.
  assign mem_addr  = id_ex.payload.sr1 + {id_ex.payload.offset[14:0], 1'b0};
  assign br_target = id_ex.pc + 16'd2 + {id_ex.payload.offset[14:0], 1'b0};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else if (advance) begin
      ex_mem.valid <= id_ex.valid;
      ex_mem.pc    <= id_ex.pc;
      ex_mem.ctrl  <= id_ex.ctrl;
      ex_mem.payload.alu_result <= (id_ex.ctrl.mem_read || id_ex.ctrl.mem_write)
                                   ? mem_addr : alu_out;
      ex_mem.payload.store_data    <= id_ex.payload.sr2;
      ex_mem.payload.branch_target <= br_target;
    end
  end

endmodule : lc3b_execute

`default_nettype wire

// File: lc3b_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_macros.svh"

module lc3b_fetch import lc3b_types::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     advance,
  input  logic     redirect,
  input  lc3b_word redirect_pc,
  input  lc3b_word instr,
  input  logic     instruction_response,
  output logic     instruction_request,
  output lc3b_word instruction_address,
  output logic     fetch_ready,
  stage_link.src   if_id
);

  lc3b_word pc;
  lc3b_word instr_pc;          // Address of the buffered instruction.
  lc3b_word instr_buf;
  logic     have_instr;
  logic     wait_branch;       // A BR is in flight.
  logic     arrived_br;

  assign instruction_address = pc;
  assign arrived_br = (instr[15:12] == op_br);

  // Ready with an instruction, or with a bubble while a branch resolves.
  assign fetch_ready = have_instr | wait_branch;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc                  <= `LC3B_RESET_PC;
      instruction_request <= 1'b0;
      have_instr          <= 1'b0;
      wait_branch         <= 1'b0;
      if_id.valid         <= 1'b0;
    end else begin
      if (instruction_request && instruction_response) begin
        instruction_request <= 1'b0;
        have_instr          <= 1'b1;
        instr_buf           <= instr;
        instr_pc            <= pc;
        pc                  <= pc + 16'd2;
        if (arrived_br)
          wait_branch <= 1'b1;   // Stop issuing until writeback decides.
      end else if (!instruction_request && !have_instr && !wait_branch) begin
        instruction_request <= 1'b1;
      end

      if (advance) begin
        if_id.valid <= have_instr;
        if (have_instr) begin
          have_instr                <= 1'b0;
          if_id.pc                  <= instr_pc;
          if_id.payload.instruction <= instr_buf;
        end
      end

      if (redirect) begin        // Resume at target or fall-through.
        pc          <= redirect_pc;
        wait_branch <= 1'b0;
      end
    end
  end

  assign if_id.ctrl = '0;  // Control is built in decode.

endmodule : lc3b_fetch

`default_nettype wire

// File: lc3b_macros.svh
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// Eight general registers, R0 to R7.
`define LC3B_NUM_REGS 8

// First fetch address out of reset.
`define LC3B_RESET_PC 16'h0000

// Later stages whose destination the interlock checks.
`define LC3B_INTERLOCK_DEPTH 3

`endif

// File: lc3b_memory.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_memory import lc3b_types::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     advance,
  stage_link.dst   ex_mem,
  stage_link.src   mem_wb,
  output logic     data_request,
  output logic     data_write,
  output lc3b_word data_address,
  output lc3b_word write_data,
  input  lc3b_word read_data,
  input  logic     data_response,
  output logic     memory_ready
);

  logic     mem_op;
  logic     done;        // Access finished, waiting for advance.
  lc3b_word load_q;

  assign mem_op = ex_mem.valid & (ex_mem.ctrl.mem_read | ex_mem.ctrl.mem_write);

  // Held stable by the frozen EX/MEM latch.
  assign data_address = ex_mem.payload.alu_result;
  assign write_data   = ex_mem.payload.store_data;
  assign data_write   = data_request & ex_mem.ctrl.mem_write;

  assign memory_ready = !mem_op | done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_request <= 1'b0;
      done         <= 1'b0;
    end else begin
      if (data_request && data_response) begin
        data_request <= 1'b0;
        done         <= 1'b1;
      end else if (mem_op && !data_request && !done) begin
        data_request <= 1'b1;
      end
      if (advance)
        done <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (data_request && data_response)
      load_q <= read_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb.valid <= 1'b0;
    end else if (advance) begin
      mem_wb.valid <= ex_mem.valid;
      mem_wb.pc    <= ex_mem.pc;
      mem_wb.ctrl  <= ex_mem.ctrl;
      mem_wb.payload.alu_result    <= ex_mem.payload.alu_result;
      mem_wb.payload.load_data     <= load_q;
      mem_wb.payload.branch_target <= ex_mem.payload.branch_target;
    end
  end

endmodule : lc3b_memory

`default_nettype wire

// File: lc3b_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_macros.svh"

module lc3b_regfile import lc3b_types::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  lc3b_reg  dest,
  input  lc3b_word in,
  input  lc3b_reg  src_a,
  input  lc3b_reg  src_b,
  output lc3b_word reg_a,
  output lc3b_word reg_b
);

  lc3b_word regs [`LC3B_NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `LC3B_NUM_REGS; i++)
        regs[i] <= '0;
    end else if (load) begin
      regs[dest] <= in;
    end
  end

  // Reads see the old value during a write.
  assign reg_a = regs[src_a];
  assign reg_b = regs[src_b];

endmodule : lc3b_regfile

`default_nettype wire

// File: lc3b_types.sv
`default_nettype none

package lc3b_types;

  typedef logic [15:0] lc3b_word;
  typedef logic [2:0]  lc3b_reg;
  typedef logic [2:0]  lc3b_nzp;   // {n, z, p}.

  typedef enum logic [3:0] {
    op_br  = 4'b0000,
    op_add = 4'b0001,
    op_and = 4'b0101,
    op_ldr = 4'b0110,
    op_str = 4'b0111,
    op_not = 4'b1001
  } lc3b_opcode;

  typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass
  } lc3b_aluop;

  typedef struct packed {
    lc3b_aluop aluop;
    logic      alumux_sel;    // 1 selects imm5.
    logic      load_regfile;
    logic      load_cc;
    logic      mem_read;
    logic      mem_write;
    logic      is_branch;
    lc3b_nzp   branch_nzp;
    lc3b_reg   dest;
    lc3b_reg   src1;
    lc3b_reg   src2;
  } lc3b_control_word;

  // Operands handed across each stage boundary.
  // The control word rides next to them on the link.
  typedef struct packed {
    lc3b_word instruction;
  } id_payload_t;

  typedef struct packed {
    lc3b_word sr1;
    lc3b_word sr2;
    lc3b_word offset;         // Sign-extended offset6 or offset9.
    lc3b_word imm5;
  } ex_payload_t;

  typedef struct packed {
    lc3b_word alu_result;     // Data address for LDR and STR.
    lc3b_word store_data;
    lc3b_word branch_target;
  } mem_payload_t;

  typedef struct packed {
    lc3b_word alu_result;
    lc3b_word load_data;
    lc3b_word branch_target;
  } wb_payload_t;

endpackage : lc3b_types

`default_nettype wire

// File: lc3b_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_writeback import lc3b_types::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     advance,
  stage_link.dst   mem_wb,
  output lc3b_reg  wb_dest,
  output lc3b_word wb_data,
  output logic     wb_load,
  output logic     redirect,
  output lc3b_word redirect_pc,
  output logic     branch_resolved,
  output logic     writeback_ready
);

  lc3b_nzp cc;
  lc3b_nzp gen_cc;
  logic    taken;

  assign wb_dest = mem_wb.ctrl.dest;
  assign wb_data = mem_wb.ctrl.mem_read ? mem_wb.payload.load_data
                                        : mem_wb.payload.alu_result;
  assign wb_load = advance & mem_wb.valid & mem_wb.ctrl.load_regfile;

  assign gen_cc = wb_data[15]       ? 3'b100 :
                  (wb_data == '0)   ? 3'b010 : 3'b001;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cc <= 3'b010;  // Z after reset.
    else if (advance && mem_wb.valid && mem_wb.ctrl.load_cc)
      cc <= gen_cc;
  end

  assign taken           = |(mem_wb.ctrl.branch_nzp & cc);
  assign branch_resolved = advance & mem_wb.valid & mem_wb.ctrl.is_branch;
  assign redirect        = branch_resolved & taken;
  assign redirect_pc     = taken ? mem_wb.payload.branch_target
                                 : mem_wb.pc + 16'd2;  // Fall-through.

  assign writeback_ready = 1'b1;  // Always completes in one cycle.

endmodule : lc3b_writeback

`default_nettype wire

// File: stage_link.sv
`timescale 1ns/1ps
`default_nettype none

// Pipeline register contents between two adjacent stages.
interface stage_link import lc3b_types::*; #(
  parameter type payload_t = logic
);

  logic             valid;
  lc3b_word         pc;       // Address of this instruction.
  lc3b_control_word ctrl;
  payload_t         payload;

  modport src (
    output valid, pc, ctrl, payload
  );

  modport dst (
    input valid, pc, ctrl, payload
  );

endinterface : stage_link

`default_nettype wire

// File: tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_macros.svh"

module tb_cpu import lc3b_types::*; ();

  localparam int imem_words = 128;
  localparam int dmem_words = 256;
  localparam int max_steps  = 1000;

  logic     clk;
  logic     rst_n;
  lc3b_word instr;
  logic     instruction_response;
  lc3b_word read_data;
  logic     data_response;
  logic     instruction_request;
  lc3b_word instruction_address;
  logic     data_request;
  logic     data_write;
  lc3b_word data_address;
  lc3b_word write_data;

  lc3b_word    imem [imem_words];
  lc3b_word    dmem [dmem_words];
  lc3b_word    ref_dmem [dmem_words];   // Private copy for the reference model.
  lc3b_word    exp_fetch [$];
  lc3b_word    exp_store_addr [$];
  lc3b_word    exp_store_data [$];
  int          prog_len;
  int          imem_wait, dmem_wait;
  int          cycle_count, timeout_limit;
  int          fetch_count, store_count;

  cpu_datapath u_dut (.*);

  bind cpu_datapath cpu_chk u_chk (.*);

  always #50 clk = ~clk;

  function automatic lc3b_word reg_form(lc3b_opcode op, lc3b_reg dr, lc3b_reg sa, lc3b_reg sb);
    return {op, dr, sa, 3'b000, sb};
  endfunction

  function automatic lc3b_word imm_form(lc3b_opcode op, lc3b_reg dr, lc3b_reg sa,
                                        logic [4:0] imm);
    return {op, dr, sa, 1'b1, imm};
  endfunction

  function automatic lc3b_word mem_form(lc3b_opcode op, lc3b_reg r, lc3b_reg base,
                                        logic [5:0] off);
    return {op, r, base, off};
  endfunction

  function automatic lc3b_word branch_form(lc3b_nzp nzp, logic [8:0] off);
    return {op_br, nzp, off};
  endfunction

  task automatic emit(lc3b_word word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic build_program();
    logic [4:0] imm [5];
    for (int i = 0; i < 5; i++)
      imm[i] = 5'($urandom());
    prog_len = 0;
    emit(imm_form(op_add, 3'd7, 3'd7, 5'd14));    // R7 points at the result block.
    emit(reg_form(op_add, 3'd7, 3'd7, 3'd7));
    emit(imm_form(op_add, 3'd1, 3'd1, imm[0]));
    emit(imm_form(op_add, 3'd2, 3'd1, imm[1]));   // Back-to-back dependency.
    emit(reg_form(op_and, 3'd3, 3'd2, 3'd1));
    emit(imm_form(op_and, 3'd4, 3'd2, imm[2]));
    emit({op_not, 3'd5, 3'd3, 6'b111111});
    emit(reg_form(op_add, 3'd6, 3'd5, 3'd4));
    for (int k = 1; k <= 6; k++)
      emit(mem_form(op_str, 3'(k), 3'd7, 6'(k - 1)));
    emit(mem_form(op_ldr, 3'd1, 3'd7, 6'b101100)); // Fill word at offset -20.
    emit(imm_form(op_add, 3'd2, 3'd1, imm[3]));
    emit({op_not, 3'd3, 3'd1, 6'b111111});
    emit(mem_form(op_str, 3'd2, 3'd7, 6'd6));
    emit(mem_form(op_str, 3'd3, 3'd7, 6'd7));
    emit(mem_form(op_ldr, 3'd4, 3'd7, 6'd2));      // Reads back an earlier store.
    emit(reg_form(op_and, 3'd5, 3'd4, 3'd1));
    emit(mem_form(op_str, 3'd5, 3'd7, 6'd8));
    // Each condition code once taken and once not taken.
    emit(imm_form(op_and, 3'd6, 3'd6, 5'd0));
    emit(branch_form(3'b010, 9'd1));
    emit(imm_form(op_add, 3'd6, 3'd6, 5'd1));
    emit(branch_form(3'b101, 9'd1));
    emit(imm_form(op_add, 3'd6, 3'd6, 5'd2));
    emit(branch_form(3'b001, 9'd1));
    emit(imm_form(op_add, 3'd6, 3'd6, 5'd4));
    emit(branch_form(3'b110, 9'd1));
    emit(imm_form(op_add, 3'd6, 3'd6, 5'b10000)); // Adding minus 16 leaves n set.
    emit(branch_form(3'b100, 9'd1));
    emit(imm_form(op_add, 3'd6, 3'd6, 5'd8));
    emit(branch_form(3'b011, 9'd1));
    emit(mem_form(op_str, 3'd6, 3'd7, 6'd9));
    // Data-dependent outcomes.
    emit(imm_form(op_add, 3'd1, 3'd1, imm[4]));
    emit(branch_form(3'b100, 9'd1));
    emit(imm_form(op_add, 3'd6, 3'd6, 5'd1));
    emit(branch_form(3'b010, 9'd1));
    emit(imm_form(op_add, 3'd6, 3'd6, 5'd3));
    emit(branch_form(3'b001, 9'd1));
    emit(imm_form(op_add, 3'd6, 3'd6, 5'd5));
    emit(mem_form(op_str, 3'd6, 3'd7, 6'd10));
    emit(branch_form(3'b111, 9'h1ff));             // Halt on a branch to itself.
  endtask

  // Instruction-level model of the program that fills the expected queues.
  function automatic int iss_run();
    lc3b_word regs [`LC3B_NUM_REGS];
    lc3b_word pc, ir, operand, addr, next_pc;
    lc3b_nzp  cc;
    lc3b_reg  dr;
    logic     halted;
    int       steps;
    for (int i = 0; i < `LC3B_NUM_REGS; i++)
      regs[i] = '0;
    pc     = `LC3B_RESET_PC;
    cc     = 3'b010;
    halted = 1'b0;
    steps  = 0;
    while (!halted && steps < max_steps) begin
      exp_fetch.push_back(pc);
      ir      = imem[pc[7:1]];
      dr      = ir[11:9];
      next_pc = pc + 16'd2;
      operand = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
      addr    = regs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
      case (lc3b_opcode'(ir[15:12]))
        op_add: regs[dr] = regs[ir[8:6]] + operand;
        op_and: regs[dr] = regs[ir[8:6]] & operand;
        op_not: regs[dr] = ~regs[ir[8:6]];
        op_ldr: regs[dr] = ref_dmem[addr[8:1]];
        op_str: begin
          ref_dmem[addr[8:1]] = regs[dr];
          exp_store_addr.push_back(addr);
          exp_store_data.push_back(regs[dr]);
        end
        op_br: begin
          if (|(ir[11:9] & cc))
            next_pc = next_pc + {{6{ir[8]}}, ir[8:0], 1'b0};
        end
        default: ;
      endcase
      if (ir[15:12] inside {op_add, op_and, op_not, op_ldr})
        cc = regs[dr][15] ? 3'b100 : ((regs[dr] == '0) ? 3'b010 : 3'b001);
      halted = (next_pc == pc);
      pc     = next_pc;
      steps++;
    end
    exp_fetch.push_back(pc);  // Two more turns of the halt loop.
    exp_fetch.push_back(pc);
    return steps + 2;
  endfunction

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_fetch(string name, lc3b_word expected, lc3b_word actual);
    if (actual !== expected)
      abort_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic check_store(string name, lc3b_word exp_addr, lc3b_word exp_data,
                             lc3b_word act_addr, lc3b_word act_data);
    if (act_addr !== exp_addr || act_data !== exp_data)
      abort_run($sformatf("mismatch %s: expected %h/%h, actual %h/%h",
                          name, exp_addr, exp_data, act_addr, act_data));
  endtask

  // Instruction memory with a random 0 to 5 cycle answer delay.
  always @(posedge clk) begin
    instruction_response <= 1'b0;
    if (!rst_n) begin
      imem_wait <= $urandom() % 6;
    end else if (instruction_request && !instruction_response) begin
      if (imem_wait == 0) begin
        instruction_response <= 1'b1;
        instr                <= imem[instruction_address[7:1]];
        imem_wait            <= $urandom() % 6;
      end else begin
        imem_wait <= imem_wait - 1;
      end
    end
  end

  always @(posedge clk) begin
    data_response <= 1'b0;
    if (!rst_n) begin
      dmem_wait <= $urandom() % 6;
    end else if (data_request && !data_response) begin
      if (dmem_wait == 0) begin
        data_response <= 1'b1;
        if (data_write)
          dmem[data_address[8:1]] <= write_data;
        else
          read_data <= dmem[data_address[8:1]];
        dmem_wait <= $urandom() % 6;
      end else begin
        dmem_wait <= dmem_wait - 1;
      end
    end
  end

  // Compares fetches and stores at their handshake edge.
  always @(posedge clk) begin
    if (!rst_n) begin
      if (instruction_request || data_request || data_write)
        abort_run("a memory request was high during reset");
    end else begin
      if (data_request && data_response && data_write) begin
        if (exp_store_data.size() == 0) begin
          abort_run("the DUT made a store that the program does not make");
        end else begin
          check_store($sformatf("store %0d", store_count), exp_store_addr.pop_front(),
                      exp_store_data.pop_front(), data_address, write_data);
          store_count++;
        end
      end
      if (instruction_request && instruction_response) begin
        check_fetch($sformatf("fetch %0d", fetch_count), exp_fetch.pop_front(),
                    instruction_address);
        fetch_count++;
        if (exp_fetch.size() == 0) begin
          if (exp_store_data.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
          end else begin
            abort_run("the program reached its halt loop with stores still missing");
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (u_dut.u_chk.error_count != 0)
      abort_run("a memory handshake assertion failed");
    else if (cycle_count >= timeout_limit)
      abort_run($sformatf("timeout after %0d cycles without reaching the halt loop",
                          cycle_count));
  end

  initial begin
    clk                  = 1'b0;
    rst_n                = 1'b0;
    instr                = '0;
    instruction_response = 1'b0;
    read_data            = '0;
    data_response        = 1'b0;
    imem_wait            = 0;
    dmem_wait            = 0;
    cycle_count          = 0;
    fetch_count          = 0;
    store_count          = 0;
    void'($urandom(32'hea8432ef));
    for (int i = 0; i < imem_words; i++)
      imem[i] = {op_br, 3'b000, 9'(i)};  // Never-taken branch tagged with its address.
    for (int i = 0; i < dmem_words; i++) begin
      dmem[i]     = 16'(i * 40503) ^ 16'h5a5a;
      ref_dmem[i] = dmem[i];
    end
    build_program();
    timeout_limit = 40 * iss_run();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule : tb_cpu

`default_nettype wire
